/* vlog.f */
+incdir+include
verilog/isaPkg.sv
verilog/pipePkg.sv
verilog/pipeReg.sv
verilog/fetchStage.sv
verilog/decodeStage.sv
verilog/executeStage.sv
verilog/memoryStage.sv
verilog/cpu.sv
tb/cpuTb.sv

/* run.sh */
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it from the project root
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module cpuTb \
	-o cpuSim > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "build failed, see build.log"
	exit 1
fi

./obj_dir/cpuSim > sim.log 2>&1
runStatus=$?
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
	exit 1
fi
if [ $runStatus -ne 0 ]; then
	echo "simulator exited with status $runStatus"
	exit 1
fi
if ! grep -q "Simulation PASSED" sim.log; then
	echo "no result line in sim.log"
	exit 1
fi
exit 0

/* tb/cpuTb.sv */
// self-checking run of one generated program; reset is held while the program loads, then 2 more cycles
`timescale 1ns/1ns
`include "cpu_settings.svh"

module cpuTb
	import isaPkg::*, pipePkg::*;
;
	logic clk, arstN, progWe, hlt;
	logic [$clog2(`CPU_IMEM_WORDS)-1:0] progAddr;
	logic [`CPU_WORD-1:0] progData, pc;
	wbT retire;

	logic [15:0] prog [256];
	string progTest [256]; // behavior that each word belongs to
	logic [19:0] expWrites [256]; // {rd, data} in retire order
	string expName [256];
	int progLen, expCount, retireIdx;
	logic [31:0] rngState;
	logic [19:0] expWord;

	cpu DUT (.clk, .arstN, .progWe, .progAddr, .progData, .pc, .hlt, .retire);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns period
	end

	function automatic logic [31:0] xorshift(logic [31:0] s);
		s ^= s << 13;
		s ^= s >> 17;
		s ^= s << 5;
		return s;
	endfunction

	task automatic failRun(string why);
		$display("%s", why);
		$display("Simulation FAILED");
		$fatal(1);
	endtask

	task automatic emit(logic [15:0] w, string test);
		prog[progLen] = w;
		progTest[progLen] = test;
		progLen++;
	endtask

	function automatic logic condHolds(logic [2:0] c, logic z, logic v, logic n);
		case (c)
			3'd0: return !z; // ne
			3'd1: return z;
			3'd2: return !z && !n; // gt
			3'd3: return n;
			3'd4: return z || !n; // ge
			3'd5: return z || n;
			3'd6: return v; // overflow
			default: return 1'b1;
		endcase
	endfunction

	// sequential model of the isa, records every register write
	task automatic runModel();
		logic [15:0] r [16];
		logic [15:0] dm [256];
		logic [15:0] w, a, b, res, addr;
		logic z, v, n;
		int i;
		for (int k = 0; k < 16; k++)
			r[k] = '0;
		{z, v, n} = 3'b000;
		i = 0;
		expCount = 0;
		while (prog[i][15:12] != 4'hF) begin
			w = prog[i];
			a = r[w[7:4]];
			b = r[w[3:0]];
			addr = a + {{11{w[3]}}, w[3:0], 1'b0}; // byte address for lw/sw
			res = 'x;
			case (w[15:12])
				4'h0, 4'h1: begin
					res = (w[15:12] == 4'h0) ? a + b : a - b;
					v = (w[15:12] == 4'h0) ? (a[15] == b[15] && res[15] != a[15])
						: (a[15] != b[15] && res[15] != a[15]);
					n = res[15];
					z = res == '0;
				end
				4'h2: begin
					res = a ^ b;
					z = res == '0; // v and n untouched
				end
				4'h8: res = dm[addr[8:1]];
				4'h9: dm[addr[8:1]] = r[w[11:8]];
				4'hA: res = {r[w[11:8]][15:8], w[7:0]};
				4'hB: res = {w[7:0], r[w[11:8]][7:0]};
				default: ;
			endcase
			if (w[15:12] == 4'hC) begin
				if (condHolds(w[11:9], z, v, n))
					i = i + {{23{w[8]}}, w[8:0]}; // skip over the wrong path
			end else if (w[15:12] != 4'h9) begin
				r[w[11:8]] = res;
				expWrites[expCount] = {w[11:8], res};
				expName[expCount] = progTest[i];
				expCount++;
			end
			i++;
		end
	endtask

	task automatic buildProgram();
		logic [3:0] rd, rs, rt, prev;
		logic [3:0] k [3];
		progLen = 0;
		// byte insertion pairs on r1..r7
		for (int j = 1; j < 8; j++) begin
			rngState = xorshift(rngState);
			emit({OP_LLB, 4'(j), rngState[7:0]}, "llbLhb");
			emit({OP_LHB, 4'(j), rngState[15:8]}, "llbLhb");
		end
		// dependent alu chain, rs always the previous result
		prev = 4'd1;
		for (int j = 0; j < 12; j++) begin
			rngState = xorshift(rngState);
			rd = 4'(1 + rngState[10:8] % 7);
			rt = 4'(1 + rngState[14:12] % 7);
			emit({4'(rngState[17:16] % 3), rd, prev, rt}, "aluChain");
			prev = rd;
		end
		// store and reload around base r8
		rngState = xorshift(rngState);
		for (int j = 0; j < 3; j++)
			k[j] = {1'b0, rngState[3*j +: 3]};
		emit({OP_LLB, 4'd8, 8'h20}, "memory");
		emit({OP_LHB, 4'd8, 8'h00}, "memory");
		emit({OP_SW, 4'd1, 4'd8, k[0]}, "memory");
		emit({OP_LW, 4'd9, 4'd8, k[0]}, "memory");
		emit({OP_ADD, 4'd10, 4'd9, 4'd9}, "memory"); // load-use
		emit({OP_LLB, 4'd2, rngState[23:16]}, "memory");
		emit({OP_SW, 4'd2, 4'd8, k[1]}, "memory"); // data just written
		emit({OP_LW, 4'd11, 4'd8, k[1]}, "memory");
		emit({OP_SW, 4'd11, 4'd8, k[2]}, "memory"); // data just loaded
		emit({OP_LW, 4'd12, 4'd8, k[2]}, "memory");
		emit({OP_ADD, 4'd10, 4'd12, 4'd11}, "memory");
		// each condition right behind a flag setter
		for (int c = 0; c < 8; c++) begin
			rngState = xorshift(rngState);
			rs = 4'(1 + rngState[2:0] % 7);
			rt = rngState[3] ? rs : 4'(1 + rngState[6:4] % 7); // sometimes zero result
			emit({4'(rngState[9:8] % 3), 4'd13, rs, rt}, "branch");
			emit({OP_B, 3'(c), 1'b0, 8'h01}, "branch");
			emit({OP_ADD, 4'd14, 4'd13, 4'd1}, "branch"); // wrong path when taken
			emit({OP_ADD, 4'd15, 4'd14, 4'd2}, "branch");
		end
		emit(16'hF000, "halt");
	endtask

	assign expWord = expWrites[retireIdx[7:0]];

	always @(posedge clk or negedge arstN) begin
		if (!arstN)
			retireIdx <= 0;
		else if (retire.regWrite)
			retireIdx <= retireIdx + 1;
	end

	assert property (@(posedge clk) disable iff (!arstN) retire.regWrite |-> retireIdx < expCount)
		else failRun("more register writes retired than the program makes");
	assert property (@(posedge clk) disable iff (!arstN)
		retire.regWrite |-> {retire.rdId, retire.data} == expWord)
		else failRun($sformatf("mismatch %s expected r%0d=%h actual r%0d=%h",
			expName[$sampled(retireIdx)], $sampled(expWord[19:16]), $sampled(expWord[15:0]),
			$sampled(retire.rdId), $sampled(retire.data)));
	assert property (@(posedge clk) disable iff (!arstN) $past(hlt) |-> hlt)
		else failRun("hlt fell after the halt retired");
	assert property (@(posedge clk) disable iff (!arstN) hlt |-> $stable(pc))
		else failRun("pc moved while halted");
	assert property (@(posedge clk) disable iff (!arstN) $past(hlt) |-> !retire.regWrite)
		else failRun("register write retired after halt");

	// watchdog sized from the program
	initial begin
		wait (arstN === 1'b1);
		#((progLen * 3 + 40) * 8);
		failRun("timeout, halt not reached");
	end

	initial begin
		arstN = 1'b0;
		progWe = 1'b0;
		progAddr = '0;
		progData = '0;
		rngState = 32'ha841_b577;
		buildProgram();
		runModel();
		for (int j = 0; j < progLen; j++) begin
			@(posedge clk);
			#1;
			progWe = 1'b1;
			progAddr = 8'(j);
			progData = prog[j];
		end
		@(posedge clk);
		#1;
		progWe = 1'b0;
		repeat (2) @(posedge clk); // reset cycles proper
		#1;
		arstN = 1'b1;
		while (hlt !== 1'b1) begin
			@(posedge clk);
			#1;
		end
		repeat (10) @(posedge clk); // quiet window after halt
		#1;
		if (retireIdx == expCount) begin
			$display("Simulation PASSED");
			$finish;
		end else begin
			failRun($sformatf("only %0d of %0d writes retired", retireIdx, expCount));
		end
	end

endmodule

/* verilog/cpu.sv */
// program loads only during reset; hlt holds while hlt words keep draining from the frozen pc
`timescale 1ns/1ns
`include "cpu_settings.svh"

module cpu
	import isaPkg::*, pipePkg::*;
(
	input  logic clk,
	input  logic arstN,
	input  logic progWe,
	input  logic [$clog2(`CPU_IMEM_WORDS)-1:0] progAddr,
	input  logic [`CPU_WORD-1:0] progData,
	output logic [`CPU_WORD-1:0] pc,
	output logic hlt,
	output wbT retire // one entry per writeback
);
	logic stall, branchTaken;
	logic [`CPU_WORD-1:0] branchTarget;
	flagsT flags;
	ifIdT ifIdD, ifIdQ;
	idExT idExD, idExQ;
	exMemT exMemD, exMemQ;
	memWbT memWbD, memWbQ;

	fetchStage fetch (.clk, .arstN, .stall, .branchTaken, .branchTarget, .progWe, .progAddr,
		.progData, .pc, .ifId(ifIdD));

	pipeReg #(.payloadT(ifIdT)) regIfId (.clk, .arstN, .hold(stall), .flush(branchTaken),
		.d(ifIdD), .q(ifIdQ));

	decodeStage decode (.clk, .arstN, .ifId(ifIdQ), .idExCtrl(idExQ.ctrl), .idExRd(idExQ.rdId),
		.flags, .memWb(memWbQ), .idEx(idExD), .wb(retire), .stall, .branchTaken, .branchTarget);

	// decode already inserts the stall bubble
	pipeReg #(.payloadT(idExT)) regIdEx (.clk, .arstN, .hold(1'b0), .flush(1'b0),
		.d(idExD), .q(idExQ));

	executeStage execute (.clk, .arstN, .idEx(idExQ), .exMemFwd(exMemQ), .wb(retire),
		.exMem(exMemD), .flags);

	pipeReg #(.payloadT(exMemT)) regExMem (.clk, .arstN, .hold(1'b0), .flush(1'b0),
		.d(exMemD), .q(exMemQ));

	memoryStage memory (.clk, .arstN, .exMem(exMemQ), .wb(retire), .memWb(memWbD));

	pipeReg #(.payloadT(memWbT)) regMemWb (.clk, .arstN, .hold(1'b0), .flush(1'b0),
		.d(memWbD), .q(memWbQ));

	assign hlt = memWbQ.halt; // hlt in writeback

endmodule

/* verilog/memoryStage.sv */
// word-addressed dmem, bit 0 of the address is ignored; stores are dropped while arstN is low
`timescale 1ns/1ns
`include "cpu_settings.svh"

module memoryStage
	import pipePkg::*;
(
	input  logic  clk,
	input  logic  arstN,
	input  exMemT exMem,
	input  wbT    wb, // instruction just ahead, in writeback
	output memWbT memWb
);
	localparam int IDX_W = $clog2(`CPU_DMEM_WORDS);

	logic [`CPU_WORD-1:0] dmem [`CPU_DMEM_WORDS];
	logic [IDX_W-1:0] idx;
	logic [`CPU_WORD-1:0] wrData;

	assign idx = exMem.aluResult[IDX_W:1];

	// lw then sw of the loaded reg, data only exists in writeback
	assign wrData = (wb.regWrite && wb.rdId == exMem.rdId) ? wb.data : exMem.storeData;

	always_ff @(posedge clk) begin
		if (arstN && exMem.memWrite)
			dmem[idx] <= wrData;
	end

	assign memWb = '{regWrite: exMem.regWrite, memToReg: exMem.memToReg, halt: exMem.halt,
		rdId: exMem.rdId, aluResult: exMem.aluResult,
		memData: exMem.memRead ? dmem[idx] : {`CPU_WORD{1'b0}}};

endmodule

/* verilog/executeStage.sv */
// no saturation, ADD/SUB wrap; loads are never forwarded from memory, decode stalls for them
`timescale 1ns/1ns
`include "cpu_settings.svh"

module executeStage
	import isaPkg::*, pipePkg::*;
(
	input  logic clk,
	input  logic arstN,
	input  idExT idEx,
	input  exMemT exMemFwd, // one instruction ahead
	input  wbT wb, // two ahead
	output exMemT exMem,
	output flagsT flags
);
	localparam int W = `CPU_WORD;

	logic [W-1:0] opA, opB, opBx, sum, result;
	logic isSub, ovf;

	// newest producer first
	function automatic logic [W-1:0] fwd(regIdT id, logic [W-1:0] regVal, exMemT em, wbT w);
		if (em.regWrite && !em.memToReg && em.rdId == id)
			return em.aluResult;
		if (w.regWrite && w.rdId == id)
			return w.data;
		return regVal;
	endfunction

	assign opA = fwd(idEx.rsId, idEx.srcA, exMemFwd, wb);
	assign opB = fwd(idEx.rtId, idEx.srcB, exMemFwd, wb);

	assign isSub = idEx.opcode == OP_SUB;
	assign opBx = isSub ? ~opB : opB; // a - b as a + ~b + 1
	assign sum = opA + opBx + W'(isSub);
	assign ovf = (opA[W-1] == opBx[W-1]) && (sum[W-1] != opA[W-1]);

	always_comb begin
		if (idEx.ctrl.loadByte)
			result = (idEx.opcode == OP_LHB) ? {idEx.imm[7:0], opB[7:0]}
				: {opB[W-1:8], idEx.imm[7:0]};
		else if (idEx.ctrl.aluSrc)
			result = opA + idEx.imm; // lw/sw byte address
		else if (idEx.opcode == OP_XOR)
			result = opA ^ opB;
		else
			result = sum;
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			flags <= '0;
		end else if (idEx.ctrl.flagWrite) begin
			flags.z <= result == '0;
			if (idEx.opcode != OP_XOR) begin // xor keeps v and n
				flags.v <= ovf;
				flags.n <= result[W-1];
			end
		end
	end

	assign exMem = '{regWrite: idEx.ctrl.regWrite, memRead: idEx.ctrl.memRead,
		memWrite: idEx.ctrl.memWrite, memToReg: idEx.ctrl.memToReg, halt: idEx.ctrl.halt,
		rdId: idEx.rdId, aluResult: result, storeData: opB};

	// an x here would reach the branch decision in decode
	assert property (@(posedge clk) disable iff (!arstN) !$isunknown(flags))
		else $error("execute: flags unknown");

endmodule

/* verilog/decodeStage.sv */
// branches see flags as of the previous cycle; stalls last one cycle and never coincide with a redirect
`timescale 1ns/1ns
`include "cpu_settings.svh"

module decodeStage
	import isaPkg::*, pipePkg::*;
(
	input  logic clk,
	input  logic arstN,
	input  ifIdT ifId,
	input  ctrlT idExCtrl, // instruction now in execute
	input  regIdT idExRd,
	input  flagsT flags,
	input  memWbT memWb,
	output idExT idEx,
	output wbT wb,
	output logic stall,
	output logic branchTaken,
	output logic [`CPU_WORD-1:0] branchTarget
);
	logic [`CPU_WORD-1:0] regs [`CPU_REGS];
	insnT insn;
	ctrlT ctrl;
	regIdT rtIdx;
	logic ifValid, isBranch, useRs, useRt, condMet, loadUse;
	logic [8:0] imm9;
	logic [`CPU_WORD-1:0] srcA, srcB, imm;

	assign insn = ifId.insn;
	assign ifValid = |ifId.pcPlus2; // flushed or reset slot

	always_comb begin
		ctrl = '0;
		if (ifValid) begin
			case (insn.opcode)
				OP_ADD, OP_SUB, OP_XOR: ctrl = '{regWrite: 1'b1, flagWrite: 1'b1, default: 1'b0};
				OP_LW: ctrl = '{regWrite: 1'b1, memRead: 1'b1, memToReg: 1'b1, aluSrc: 1'b1,
					default: 1'b0};
				OP_SW: ctrl = '{memWrite: 1'b1, aluSrc: 1'b1, default: 1'b0};
				OP_LLB, OP_LHB: ctrl = '{regWrite: 1'b1, loadByte: 1'b1, default: 1'b0};
				OP_HLT: ctrl = '{halt: 1'b1, default: 1'b0};
				default: ctrl = '0; // b and unknown opcodes write nothing
			endcase
		end
	end

	assign isBranch = ifValid && insn.opcode == OP_B;
	assign rtIdx = (ctrl.loadByte || ctrl.memWrite) ? insn.rd : insn.rt; // old rd / store data
	assign useRs = ctrl.flagWrite || ctrl.aluSrc;
	assign useRt = ctrl.flagWrite || ctrl.loadByte; // sw data is caught in memory

	assign wb = '{regWrite: memWb.regWrite, rdId: memWb.rdId,
		data: memWb.memToReg ? memWb.memData : memWb.aluResult};

	// write before read
	assign srcA = (wb.regWrite && wb.rdId == insn.rs) ? wb.data : regs[insn.rs];
	assign srcB = (wb.regWrite && wb.rdId == rtIdx) ? wb.data : regs[rtIdx];

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < `CPU_REGS; i++)
				regs[i] <= '0;
		end else if (wb.regWrite) begin
			regs[wb.rdId] <= wb.data;
		end
	end

	assign imm = ctrl.aluSrc ? {{(`CPU_WORD-5){insn.rt[3]}}, insn.rt, 1'b0} // byte offset
		: {{(`CPU_WORD-8){1'b0}}, imm8Of(insn)};

	assign loadUse = idExCtrl.memRead
		&& ((useRs && idExRd == insn.rs) || (useRt && idExRd == rtIdx));
	assign stall = loadUse || (isBranch && idExCtrl.flagWrite); // wait for flags to land

	always_comb begin
		case (condOf(insn))
			C_NE: condMet = !flags.z;
			C_EQ: condMet = flags.z;
			C_GT: condMet = !flags.z && !flags.n;
			C_LT: condMet = flags.n;
			C_GE: condMet = flags.z || !flags.n;
			C_LE: condMet = flags.z || flags.n;
			C_OV: condMet = flags.v;
			default: condMet = 1'b1; // unconditional
		endcase
	end

	assign imm9 = imm9Of(insn);
	assign branchTarget = ifId.pcPlus2 + {{(`CPU_WORD-10){imm9[8]}}, imm9, 1'b0};
	assign branchTaken = isBranch && condMet && !idExCtrl.flagWrite;

	always_comb begin
		idEx = '{ctrl: ctrl, opcode: insn.opcode, rsId: insn.rs, rtId: rtIdx, rdId: insn.rd,
			srcA: srcA, srcB: srcB, imm: imm};
		if (stall)
			idEx = '0; // bubble into execute
	end

	assert property (@(posedge clk) disable iff (!arstN) !(stall && branchTaken))
		else $error("decode: stall during branch redirect");

endmodule

/* verilog/fetchStage.sv */
// imem is written only while arstN is low; the pc indexes words through bits above bit 0
`timescale 1ns/1ns
`include "cpu_settings.svh"

module fetchStage
	import isaPkg::*, pipePkg::*;
(
	input  logic clk,
	input  logic arstN,
	input  logic stall, // load-use or flag hazard in decode
	input  logic branchTaken,
	input  logic [`CPU_WORD-1:0] branchTarget,
	input  logic progWe,
	input  logic [$clog2(`CPU_IMEM_WORDS)-1:0] progAddr, // word index
	input  logic [`CPU_WORD-1:0] progData,
	output logic [`CPU_WORD-1:0] pc,
	output ifIdT ifId
);
	localparam int IDX_W = $clog2(`CPU_IMEM_WORDS);

	logic [`CPU_WORD-1:0] imem [`CPU_IMEM_WORDS];
	insnT insn;
	logic [`CPU_WORD-1:0] pcPlus2;
	logic [`CPU_WORD-1:0] pcNext;

	assign insn = insnT'(imem[pc[IDX_W:1]]); // async read
	assign pcPlus2 = pc + `CPU_WORD'(2);

	// redirect beats hlt, so a wrong-path hlt never freezes the pc
	always_comb begin
		if (branchTaken)
			pcNext = branchTarget;
		else if (stall || insn.opcode == OP_HLT)
			pcNext = pc; // refetch same word
		else
			pcNext = pcPlus2;
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			pc <= '0;
		else
			pc <= pcNext;
	end

	always_ff @(posedge clk) begin
		if (!arstN && progWe)
			imem[progAddr] <= progData; // program load port
	end

	assign ifId = '{pcPlus2: pcPlus2, insn: insn};

endmodule

/* verilog/pipeReg.sv */
// one stage register for any packed payload; flush and reset load all zeros, hold wins over d
`timescale 1ns/1ns

module pipeReg #(
	parameter type payloadT = logic
) (
	input  logic    clk,
	input  logic    arstN,
	input  logic    hold, // keep current contents
	input  logic    flush, // load a bubble
	input  payloadT d,
	output payloadT q
);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			q <= '0;
		else if (flush)
			q <= '0; // squashed slot
		else if (!hold)
			q <= d;
	end

	// stall and redirect come from the same decode cycle, they must exclude each other
	assert property (@(posedge clk) disable iff (!arstN) !(hold && flush))
		else $error("pipeReg: hold and flush high together");

endmodule

/* verilog/pipePkg.sv */
// stage bundles; all zero is a bubble, except ifIdT where only pcPlus2 of zero marks one
package pipePkg;
	import isaPkg::*;
	`include "cpu_settings.svh"

	typedef struct packed {
		logic [`CPU_WORD-1:0] pcPlus2; // never zero for a fetched word
		insnT insn;
	} ifIdT;

	typedef struct packed {
		logic regWrite;
		logic memRead;
		logic memWrite;
		logic memToReg;
		logic aluSrc; // lw/sw address add
		logic loadByte; // llb/lhb
		logic flagWrite;
		logic halt;
	} ctrlT;

	typedef struct packed {
		ctrlT ctrl;
		opcodeT opcode;
		regIdT rsId;
		regIdT rtId; // rd for llb/lhb/sw
		regIdT rdId;
		logic [`CPU_WORD-1:0] srcA;
		logic [`CPU_WORD-1:0] srcB;
		logic [`CPU_WORD-1:0] imm; // already extended
	} idExT;

	typedef struct packed {
		logic regWrite;
		logic memRead;
		logic memWrite;
		logic memToReg;
		logic halt;
		regIdT rdId; // store source for sw
		logic [`CPU_WORD-1:0] aluResult;
		logic [`CPU_WORD-1:0] storeData;
	} exMemT;

	typedef struct packed {
		logic regWrite;
		logic memToReg;
		logic halt;
		regIdT rdId;
		logic [`CPU_WORD-1:0] aluResult;
		logic [`CPU_WORD-1:0] memData;
	} memWbT;

	// writeback bundle, also the retire port
	typedef struct packed {
		logic regWrite;
		regIdT rdId;
		logic [`CPU_WORD-1:0] data;
	} wbT;

endpackage

/* verilog/isaPkg.sv */
// subset of the 16-bit isa only; opcodes outside the enum decode as no-ops
package isaPkg;

	typedef enum logic [3:0] {
		OP_ADD = 4'h0,
		OP_SUB = 4'h1,
		OP_XOR = 4'h2,
		OP_LW  = 4'h8, // rt <- mem[rs + 2*off]
		OP_SW  = 4'h9,
		OP_LLB = 4'hA,
		OP_LHB = 4'hB,
		OP_B   = 4'hC, // conditional, pc relative
		OP_HLT = 4'hF
	} opcodeT;

	typedef logic [3:0] regIdT;

	// order matches the 3-bit ccc field
	typedef enum logic [2:0] {
		C_NE, C_EQ, C_GT, C_LT, C_GE, C_LE, C_OV, C_UN
	} condT;

	typedef struct packed {
		logic z;
		logic v;
		logic n;
	} flagsT;

	typedef struct packed {
		opcodeT opcode;
		regIdT rd; // also rt of lw/sw, or ccc plus imm msb
		regIdT rs;
		regIdT rt; // also the 4-bit memory offset
	} insnT;

	function automatic condT condOf(insnT i);
		return condT'(i.rd[3:1]);
	endfunction

	function automatic logic [8:0] imm9Of(insnT i);
		return {i.rd[0], i.rs, i.rt}; // branch offset in words
	endfunction

	function automatic logic [7:0] imm8Of(insnT i);
		return {i.rs, i.rt}; // llb/lhb byte
	endfunction

endpackage

/* include/cpu_settings.svh */
// shared widths and depths; memory depths must be powers of two, pc and data share one width
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// data and byte address width
`define CPU_WORD 16

`define CPU_REGS 16 // register file entries

// word counts, indexed by address bits above bit 0
`define CPU_IMEM_WORDS 256
`define CPU_DMEM_WORDS 256

`endif
